/* logic/priv_pkg.sv */
package priv_pkg;

    // data, address and csr index words
    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;
    typedef logic [11:0] csr_idx_t;

    // csr read-modify-write operation
    typedef enum logic [1:0] {
        op_none = 2'b00,
        op_rw   = 2'b01,
        op_rs   = 2'b10,
        op_rc   = 2'b11
    } csr_op_t;

    // timer register select
    typedef enum logic {
        sel_mtime    = 1'b0,
        sel_mtimecmp = 1'b1
    } tmr_sel_t;

    // machine trap setup and handling
    localparam csr_idx_t csr_mstatus   = 12'h300;
    localparam csr_idx_t csr_misa      = 12'h301;
    localparam csr_idx_t csr_mie       = 12'h304;
    localparam csr_idx_t csr_mtvec     = 12'h305;
    localparam csr_idx_t csr_mscratch  = 12'h340;
    localparam csr_idx_t csr_mepc      = 12'h341;
    localparam csr_idx_t csr_mcause    = 12'h342;
    localparam csr_idx_t csr_mip       = 12'h344;

    // counters
    localparam csr_idx_t csr_mcycle    = 12'hb00;
    localparam csr_idx_t csr_minstret  = 12'hb02;

    // read-only identification
    localparam csr_idx_t csr_mvendorid = 12'hf11;
    localparam csr_idx_t csr_marchid   = 12'hf12;
    localparam csr_idx_t csr_mimpid    = 12'hf13;
    localparam csr_idx_t csr_mhartid   = 12'hf14;

    // mstatus fields
    localparam int mstatus_mie    = 3;
    localparam int mstatus_mpie   = 7;
    localparam int mstatus_mpp_lo = 11;
    localparam int mstatus_fs_lo  = 13;
    localparam int mstatus_xs_lo  = 15;
    localparam int mstatus_sd     = 63;

    // timer interrupt bit, shared by mip and mie
    localparam int mip_mtip = 7;

    // trap causes
    localparam xlen_t cause_ecall_m    = 64'd11;
    localparam xlen_t cause_breakpoint = 64'd3;
    localparam xlen_t cause_timer_irq  = {1'b1, 63'd7};

    // mxl = 2 (64 bit), base integer isa only
    localparam xlen_t misa_value    = {2'b10, 36'd0, 26'h000_0100};
    localparam xlen_t marchid_value = 64'd1;

endpackage

/* logic/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer #(
    parameter int unsigned TICK_DIV = 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               tmr_wr_en,
    input  priv_pkg::tmr_sel_t tmr_sel,
    input  priv_pkg::xlen_t    tmr_wdata,
    output priv_pkg::xlen_t    tmr_rdata,
    output logic               clint_mtip,
    output logic               clint_update
);
    import priv_pkg::*;

    localparam int unsigned DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic             wr_mtime;
    logic             wr_mtimecmp;
    logic             cmp_written;
    xlen_t            mtime_q;
    xlen_t            mtimecmp_q;

    assign tick        = (div_cnt == DIV_LAST);
    assign wr_mtime    = tmr_wr_en && (tmr_sel == sel_mtime);
    assign wr_mtimecmp = tmr_wr_en && (tmr_sel == sel_mtimecmp);

    // prescaler, restarts when mtime is loaded
    always_ff @(posedge clk) begin
        if (rst || wr_mtime || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else if (wr_mtime) begin
            mtime_q <= tmr_wdata;
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // all ones keeps the compare false out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;
        end else if (wr_mtimecmp) begin
            mtimecmp_q <= tmr_wdata;
        end
    end

    // update pulse lands in the same cycle as the compare
    // against the newly written mtimecmp
    always_ff @(posedge clk) begin
        if (rst) begin
            clint_mtip   <= 1'b0;
            cmp_written  <= 1'b0;
            clint_update <= 1'b0;
        end else begin
            clint_mtip   <= (mtime_q >= mtimecmp_q);
            cmp_written  <= wr_mtimecmp;
            clint_update <= cmp_written;
        end
    end

    assign tmr_rdata = (tmr_sel == sel_mtimecmp) ? mtimecmp_q : mtime_q;

    // mtimecmp is never written on back-to-back cycles
    a_update_single: assert property (@(posedge clk) disable iff (rst)
        clint_update |=> !clint_update)
        else $error("clint_update high for two cycles");

endmodule

/* logic/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
    parameter int unsigned HART_ID = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  priv_pkg::addr_t    inst_addr,
    input  priv_pkg::csr_idx_t csr_index,
    input  priv_pkg::csr_op_t  csr_op,
    input  logic               csr_src,
    input  priv_pkg::xlen_t    rs1_data,
    input  priv_pkg::xlen_t    imm_csr,
    input  logic               take_trap,
    input  logic               inst_ecall,
    input  logic               inst_ebreak,
    input  logic               inst_mret,
    input  logic               clint_mtip,
    input  logic               clint_update,
    output priv_pkg::xlen_t    csr_read,
    output priv_pkg::addr_t    csr_nxt_pc,
    output logic               irq_pending
);
    import priv_pkg::*;

    localparam xlen_t IRQ_MASK = xlen_t'(1) << mip_mtip;

    xlen_t mstatus_q;
    xlen_t mtvec_q;
    addr_t mepc_q;
    xlen_t mcause_q;
    xlen_t mip_q;
    xlen_t mie_q;
    xlen_t mscratch_q;
    xlen_t mcycle_q;
    xlen_t minstret_q;

    xlen_t csr_src_val;
    xlen_t csr_wdata;
    xlen_t mstatus_wr;
    logic  csr_wr;
    logic  trap_en;
    logic  ret_en;

    logic  wr_mstatus;
    logic  wr_mtvec;
    logic  wr_mepc;
    logic  wr_mcause;
    logic  wr_mip;
    logic  wr_mie;
    logic  wr_mscratch;
    logic  wr_mcycle;
    logic  wr_minstret;

    assign csr_wr  = inst_valid && (csr_op != op_none);
    assign trap_en = inst_valid && take_trap;
    assign ret_en  = inst_valid && inst_mret;

    assign wr_mstatus  = csr_wr && (csr_index == csr_mstatus);
    assign wr_mtvec    = csr_wr && (csr_index == csr_mtvec);
    assign wr_mepc     = csr_wr && (csr_index == csr_mepc);
    assign wr_mcause   = csr_wr && (csr_index == csr_mcause);
    assign wr_mip      = csr_wr && (csr_index == csr_mip);
    assign wr_mie      = csr_wr && (csr_index == csr_mie);
    assign wr_mscratch = csr_wr && (csr_index == csr_mscratch);
    assign wr_mcycle   = csr_wr && (csr_index == csr_mcycle);
    assign wr_minstret = csr_wr && (csr_index == csr_minstret);

    // read mux, pre-edge values
    always_comb begin
        case (csr_index)
            csr_mstatus:   csr_read = mstatus_q;
            csr_mtvec:     csr_read = mtvec_q;
            csr_mepc:      csr_read = mepc_q;
            csr_mcause:    csr_read = mcause_q;
            csr_mip:       csr_read = mip_q;
            csr_mie:       csr_read = mie_q;
            csr_mscratch:  csr_read = mscratch_q;
            csr_mcycle:    csr_read = mcycle_q;
            csr_minstret:  csr_read = minstret_q;
            csr_misa:      csr_read = misa_value;
            csr_marchid:   csr_read = marchid_value;
            csr_mhartid:   csr_read = xlen_t'(HART_ID);
            default:       csr_read = '0;
        endcase
    end

    assign csr_src_val = csr_src ? imm_csr : rs1_data;

    always_comb begin
        case (csr_op)
            op_rw:   csr_wdata = csr_src_val;
            op_rs:   csr_wdata = csr_read | csr_src_val;
            op_rc:   csr_wdata = csr_read & ~csr_src_val;
            default: csr_wdata = csr_read;
        endcase
    end

    // sd summarizes dirty fs or xs
    always_comb begin
        mstatus_wr = csr_wdata;
        mstatus_wr[mstatus_sd] = (csr_wdata[mstatus_fs_lo +: 2] == 2'b11) ||
                                 (csr_wdata[mstatus_xs_lo +: 2] == 2'b11);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (wr_mstatus) begin
            mstatus_q <= mstatus_wr;
        end else if (trap_en) begin
            mstatus_q[mstatus_mpie]        <= mstatus_q[mstatus_mie];
            mstatus_q[mstatus_mie]         <= 1'b0;
            mstatus_q[mstatus_mpp_lo +: 2] <= 2'b11;
        end else if (ret_en) begin
            mstatus_q[mstatus_mie]         <= mstatus_q[mstatus_mpie];
            mstatus_q[mstatus_mpie]        <= 1'b1;
            mstatus_q[mstatus_mpp_lo +: 2] <= 2'b00;
        end
    end

    // direct mode only, base is word aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q <= {csr_wdata[63:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else begin
            if (wr_mepc) begin
                mepc_q <= csr_wdata;
            end else if (trap_en) begin
                mepc_q <= inst_addr;
            end
            if (wr_mcause) begin
                mcause_q <= csr_wdata;
            end else if (trap_en) begin
                if (inst_ecall) begin
                    mcause_q <= cause_ecall_m;
                end else if (inst_ebreak) begin
                    mcause_q <= cause_breakpoint;
                end else begin
                    mcause_q <= cause_timer_irq;
                end
            end
        end
    end

    // mtip sets on the level, clears only after mtimecmp moves
    always_ff @(posedge clk) begin
        if (rst) begin
            mip_q <= '0;
        end else if (wr_mip) begin
            mip_q <= csr_wdata & IRQ_MASK;
        end else if (clint_mtip || clint_update) begin
            mip_q[mip_mtip] <= clint_mtip;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q      <= '0;
            mscratch_q <= '0;
        end else begin
            if (wr_mie) begin
                mie_q <= csr_wdata & IRQ_MASK;
            end
            if (wr_mscratch) begin
                mscratch_q <= csr_wdata;
            end
        end
    end

    // counters, a csr write replaces the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= wr_mcycle ? csr_wdata : mcycle_q + 64'd1;
            if (wr_minstret) begin
                minstret_q <= csr_wdata;
            end else if (inst_valid) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

    assign irq_pending = mstatus_q[mstatus_mie] && mie_q[mip_mtip] && mip_q[mip_mtip];
    assign csr_nxt_pc  = take_trap ? mtvec_q : mepc_q;

    // a retiring instruction never traps and returns at once
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (rst)
        !(inst_valid && take_trap && inst_mret))
        else $error("trap and mret on the same instruction");

endmodule

/* logic/trap_sequencer.sv */
`timescale 1ns/1ps

module trap_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  logic            inst_ecall,
    input  logic            inst_ebreak,
    input  logic            inst_mret,
    input  logic            irq_pending,
    input  priv_pkg::addr_t csr_nxt_pc,
    output logic            take_trap,
    output logic            redirect_valid,
    output priv_pkg::addr_t redirect_pc
);

    logic redirect_req;

    // exceptions first, a pending timer irq rides on any instruction
    assign take_trap    = inst_ecall || inst_ebreak || irq_pending;
    assign redirect_req = inst_valid && (take_trap || inst_mret);

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= redirect_req;
        end
    end

    // target sampled before the csr file updates mtvec or mepc
    always_ff @(posedge clk) begin
        if (redirect_req) begin
            redirect_pc <= csr_nxt_pc;
        end
    end

    // fetch target must be word aligned
    a_redirect_aligned: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> (redirect_pc[1:0] == 2'b00))
        else $error("misaligned redirect target");

endmodule

/* logic/priv_unit_top.sv */
`timescale 1ns/1ps

module priv_unit_top #(
    parameter int unsigned HART_ID  = 0,
    parameter int unsigned TICK_DIV = 1
) (
    input  logic               clk,
    input  logic               rst,

    // retiring instruction
    input  logic               inst_valid,
    input  priv_pkg::addr_t    inst_addr,
    input  priv_pkg::csr_idx_t csr_index,
    input  priv_pkg::csr_op_t  csr_op,
    input  logic               csr_src,
    input  priv_pkg::xlen_t    rs1_data,
    input  priv_pkg::xlen_t    imm_csr,
    input  logic               inst_ecall,
    input  logic               inst_ebreak,
    input  logic               inst_mret,

    // timer register port
    input  logic               tmr_wr_en,
    input  priv_pkg::tmr_sel_t tmr_sel,
    input  priv_pkg::xlen_t    tmr_wdata,
    output priv_pkg::xlen_t    tmr_rdata,

    output priv_pkg::xlen_t    csr_read,
    output logic               irq_pending,
    output logic               redirect_valid,
    output priv_pkg::addr_t    redirect_pc
);
    import priv_pkg::*;

    logic  clint_mtip;
    logic  clint_update;
    logic  take_trap;
    addr_t csr_nxt_pc;

    clint_timer #(
        .TICK_DIV(TICK_DIV)
    ) u_clint_timer (
        .clk          (clk),
        .rst          (rst),
        .tmr_wr_en    (tmr_wr_en),
        .tmr_sel      (tmr_sel),
        .tmr_wdata    (tmr_wdata),
        .tmr_rdata    (tmr_rdata),
        .clint_mtip   (clint_mtip),
        .clint_update (clint_update)
    );

    csr_file #(
        .HART_ID(HART_ID)
    ) u_csr_file (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst_addr    (inst_addr),
        .csr_index    (csr_index),
        .csr_op       (csr_op),
        .csr_src      (csr_src),
        .rs1_data     (rs1_data),
        .imm_csr      (imm_csr),
        .take_trap    (take_trap),
        .inst_ecall   (inst_ecall),
        .inst_ebreak  (inst_ebreak),
        .inst_mret    (inst_mret),
        .clint_mtip   (clint_mtip),
        .clint_update (clint_update),
        .csr_read     (csr_read),
        .csr_nxt_pc   (csr_nxt_pc),
        .irq_pending  (irq_pending)
    );

    trap_sequencer u_trap_sequencer (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_ecall     (inst_ecall),
        .inst_ebreak    (inst_ebreak),
        .inst_mret      (inst_mret),
        .irq_pending    (irq_pending),
        .csr_nxt_pc     (csr_nxt_pc),
        .take_trap      (take_trap),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* sim/priv_unit_tasks.svh */
task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
        err_count = err_count + 1;
        $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
        $display("sim failed");
        $fatal(1, "stopping at the first mismatch");
    end
endtask

// one instruction slot, held until the next drive
task automatic drive_inst(input logic valid, input addr_t addr, input csr_idx_t idx,
                          input csr_op_t op, input logic src, input xlen_t data,
                          input logic [2:0] sys);
    @(posedge clk);
    inst_valid  <= valid;
    inst_addr   <= addr;
    csr_index   <= idx;
    csr_op      <= op;
    csr_src     <= src;
    // unused source gets the complement
    rs1_data    <= src ? ~data : data;
    imm_csr     <= src ? data : ~data;
    inst_ecall  <= sys[2];
    inst_ebreak <= sys[1];
    inst_mret   <= sys[0];
    tmr_wr_en   <= 1'b0;
    @(negedge clk);
endtask

task automatic idle_cycle();
    drive_inst(1'b0, '0, csr_mstatus, op_none, 1'b0, '0, 3'b000);
endtask

task automatic expect_csr(input string what, input csr_idx_t idx, input xlen_t exp);
    drive_inst(1'b0, '0, idx, op_none, 1'b0, '0, 3'b000);
    check_value(what, csr_read, exp);
endtask

task automatic csr_access(input csr_idx_t idx, input csr_op_t op, input logic src,
                          input xlen_t data, output xlen_t old);
    drive_inst(1'b1, 64'h8000_0000, idx, op, src, data, 3'b000);
    old = csr_read;
endtask

task automatic timer_access(input logic wr, input tmr_sel_t sel, input xlen_t data,
                            output xlen_t value);
    @(posedge clk);
    inst_valid  <= 1'b0;
    csr_op      <= op_none;
    inst_ecall  <= 1'b0;
    inst_ebreak <= 1'b0;
    inst_mret   <= 1'b0;
    tmr_wr_en   <= wr;
    tmr_sel     <= sel;
    tmr_wdata   <= data;
    @(negedge clk);
    value = tmr_rdata;
endtask

// sys is {ecall, ebreak, mret}
task automatic system_inst(input addr_t addr, input logic [2:0] sys, input addr_t target);
    drive_inst(1'b1, addr, csr_mscratch, op_none, 1'b0, '0, sys);
    check_value("redirect_valid in the instruction cycle", xlen_t'(redirect_valid), 64'd0);
    idle_cycle();
    check_value("redirect_valid", xlen_t'(redirect_valid), 64'd1);
    check_value("redirect_pc", redirect_pc, target);
    idle_cycle();
    check_value("redirect_valid one cycle later", xlen_t'(redirect_valid), 64'd0);
endtask

task automatic reset_state_checks();
    // mxl = 2 in the top bits, I extension bit 8
    expect_csr("misa", csr_misa, 64'h8000_0000_0000_0100);
    expect_csr("mhartid", csr_mhartid, 64'd0);
    expect_csr("mvendorid", csr_mvendorid, 64'd0);
    expect_csr("mimpid", csr_mimpid, 64'd0);
    expect_csr("marchid", csr_marchid, 64'd1);
    expect_csr("mstatus", csr_mstatus, 64'd0);
    expect_csr("mtvec", csr_mtvec, 64'd0);
    expect_csr("mepc", csr_mepc, 64'd0);
    expect_csr("mcause", csr_mcause, 64'd0);
    check_value("irq_pending", xlen_t'(irq_pending), 64'd0);
    check_value("redirect_valid", xlen_t'(redirect_valid), 64'd0);
endtask

task automatic csr_rmw_ops();
    xlen_t   data;
    xlen_t   old;
    xlen_t   model;
    csr_op_t op;
    int      i;
    model = '0;
    // rw, rs, rc, each from rs1 then from the immediate
    for (i = 0; i < 6; i = i + 1) begin
        data = {$random(seed), $random(seed)};
        op = (i < 2) ? op_rw : ((i < 4) ? op_rs : op_rc);
        csr_access(csr_mscratch, op, i[0], data, old);
        check_value("mscratch old value", old, model);
        case (op)
            op_rw:   model = data;
            op_rs:   model = model | data;
            default: model = model & ~data;
        endcase
        expect_csr("mscratch", csr_mscratch, model);
    end
    data = {$random(seed), $random(seed)};
    csr_access(csr_mtvec, op_rw, 1'b0, data, old);
    expect_csr("mtvec", csr_mtvec, data & ~64'h3);
    csr_access(csr_mie, op_rw, 1'b1, '1, old);
    expect_csr("mie", csr_mie, 64'h80);
    csr_access(csr_mie, op_rw, 1'b0, '0, old);
endtask

task automatic ecall_ebreak_traps();
    xlen_t old;
    csr_access(csr_mtvec, op_rw, 1'b0, 64'h8000_0100, old);
    csr_access(csr_mstatus, op_rw, 1'b0, 64'h8, old);
    system_inst(64'h8000_1000, 3'b100, 64'h8000_0100);
    expect_csr("mepc after ecall", csr_mepc, 64'h8000_1000);
    expect_csr("mcause after ecall", csr_mcause, 64'd11);
    // mpie took mie = 1, mpp = 11
    expect_csr("mstatus after ecall", csr_mstatus, 64'h1880);
    system_inst(64'h8000_1004, 3'b010, 64'h8000_0100);
    expect_csr("mepc after ebreak", csr_mepc, 64'h8000_1004);
    expect_csr("mcause after ebreak", csr_mcause, 64'd3);
    expect_csr("mstatus after ebreak", csr_mstatus, 64'h1800);
endtask

task automatic mret_return();
    xlen_t old;
    csr_access(csr_mepc, op_rw, 1'b0, 64'h8000_2000, old);
    csr_access(csr_mstatus, op_rw, 1'b0, 64'h1880, old);
    system_inst(64'h8000_1008, 3'b001, 64'h8000_2000);
    // mie from mpie, mpie = 1, mpp = 00
    expect_csr("mstatus after mret", csr_mstatus, 64'h88);
endtask

task automatic timer_interrupt();
    xlen_t now;
    xlen_t old;
    xlen_t cmp;
    timer_access(1'b1, sel_mtime, 64'h100, old);
    timer_access(1'b0, sel_mtime, '0, now);
    check_value("mtime after write", now, 64'h100);
    // one mtime step every two clocks
    repeat (19) idle_cycle();
    timer_access(1'b0, sel_mtime, '0, now);
    check_value("mtime after 20 cycles", now, 64'h100 + 64'd10);
    cmp = now + 64'd20;
    timer_access(1'b1, sel_mtimecmp, cmp, old);
    timer_access(1'b0, sel_mtimecmp, '0, old);
    check_value("mtimecmp", old, cmp);
    csr_access(csr_mie, op_rw, 1'b0, 64'h80, old);
    csr_access(csr_mstatus, op_rs, 1'b1, 64'h8, old);
    // bounded by the run timeout
    while (irq_pending !== 1'b1) begin
        idle_cycle();
    end
    system_inst(64'h8000_3000, 3'b000, 64'h8000_0100);
    expect_csr("mcause after timer irq", csr_mcause, 64'h8000_0000_0000_0007);
    expect_csr("mepc after timer irq", csr_mepc, 64'h8000_3000);
    csr_access(csr_mstatus, op_rs, 1'b0, 64'h8, old);
    timer_access(1'b1, sel_mtimecmp, '1, old);
    check_value("irq_pending before clear", xlen_t'(irq_pending), 64'd1);
    // write edge, then mtip, then mip
    repeat (2) idle_cycle();
    check_value("irq_pending during clear", xlen_t'(irq_pending), 64'd1);
    idle_cycle();
    check_value("irq_pending after update", xlen_t'(irq_pending), 64'd0);
    csr_access(csr_mie, op_rw, 1'b0, '0, old);
endtask

task automatic counter_increments();
    xlen_t first;
    xlen_t second;
    csr_access(csr_minstret, op_none, 1'b0, '0, first);
    repeat (5) drive_inst(1'b1, 64'h8000_4000, csr_mscratch, op_none, 1'b0, '0, 3'b000);
    csr_access(csr_minstret, op_none, 1'b0, '0, second);
    check_value("minstret delta", second - first, 64'd6);
    csr_access(csr_mcycle, op_none, 1'b0, '0, first);
    repeat (6) idle_cycle();
    csr_access(csr_mcycle, op_none, 1'b0, '0, second);
    check_value("mcycle delta", second - first, 64'd7);
endtask

/* sim/priv_unit_tb.sv */
`timescale 1ns/1ps

module priv_unit_tb;
    import priv_pkg::*;

    // the timer test waits about 40 cycles, the rest well under 200
    localparam int TIMEOUT_CYCLES = 4000;

    logic     clk;
    logic     rst;
    logic     inst_valid;
    addr_t    inst_addr;
    csr_idx_t csr_index;
    csr_op_t  csr_op;
    logic     csr_src;
    xlen_t    rs1_data;
    xlen_t    imm_csr;
    logic     inst_ecall;
    logic     inst_ebreak;
    logic     inst_mret;
    logic     tmr_wr_en;
    tmr_sel_t tmr_sel;
    xlen_t    tmr_wdata;
    xlen_t    tmr_rdata;
    xlen_t    csr_read;
    logic     irq_pending;
    logic     redirect_valid;
    addr_t    redirect_pc;

    integer   seed;
    int       err_count;
    int       cycle_count;

    priv_unit_top #(
        .HART_ID  (0),
        .TICK_DIV (2)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $fatal(1, "run stopped by the cycle limit");
    end

    `include "priv_unit_tasks.svh"

    initial begin
        seed        = 32'hbf77_cd65;
        err_count   = 0;
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst_addr   = '0;
        csr_index   = csr_mstatus;
        csr_op      = op_none;
        csr_src     = 1'b0;
        rs1_data    = '0;
        imm_csr     = '0;
        inst_ecall  = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret   = 1'b0;
        tmr_wr_en   = 1'b0;
        tmr_sel     = sel_mtime;
        tmr_wdata   = '0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        reset_state_checks();
        csr_rmw_ops();
        ecall_ebreak_traps();
        mret_return();
        timer_interrupt();
        counter_increments();

        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+sim
logic/priv_pkg.sv
logic/clint_timer.sv
logic/csr_file.sv
logic/trap_sequencer.sv
logic/priv_unit_top.sv
sim/priv_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module priv_unit_tb -o priv_unit_sim

# a fatal stop exits non-zero, the log decides the result
./obj_dir/priv_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
